/* openram_sram_model.sv */
`timescale 1ns/1ns

`include "openram_wb_settings.svh"

module openram_sram_model
    import openram_wb_pkg::*;
(
    // Port 0, read-write
    input  logic                       ram_clk0_i,
    input  logic                       ram_csb0_i,     // Active low select
    input  logic                       ram_web0_i,     // Active low write
    input  wb_sel_t                    ram_wmask0_i,
    input  logic [`RAM_ADDR_WIDTH-1:0] ram_addr0_i,
    input  wb_data_t                   ram_din0_i,
    output wb_data_t                   ram_dout0_o,

    // Port 1, read only
    input  logic                       ram_clk1_i,
    input  logic                       ram_csb1_i,
    input  logic [`RAM_ADDR_WIDTH-1:0] ram_addr1_i,
    output wb_data_t                   ram_dout1_o
);

    localparam int DEPTH = 1 << `RAM_ADDR_WIDTH;

    wb_data_t mem [0:DEPTH-1] = '{default: '0};     // Starts cleared

    // Port 0, byte-masked write or registered read
    always_ff @(posedge ram_clk0_i) begin
        if (!ram_csb0_i) begin
            if (!ram_web0_i) begin
                for (int i = 0; i < `WB_SEL_WIDTH; i++) begin
                    if (ram_wmask0_i[i]) begin
                        mem[ram_addr0_i][8*i +: 8] <= ram_din0_i[8*i +: 8];
                    end
                end
            end else begin
                ram_dout0_o <= mem[ram_addr0_i];
            end
        end
    end

    // Port 1 read
    always_ff @(posedge ram_clk1_i) begin
        if (!ram_csb1_i) begin
            ram_dout1_o <= mem[ram_addr1_i];
        end
    end

endmodule

/* openram_wb.f */
+incdir+.
openram_wb_pkg.sv
wb_csr_bank.sv
wb_port_control.sv
wb_openram_wrapper.sv
openram_sram_model.sv
openram_wb_subsys.sv
tb_openram_wb.sv

/* openram_wb_pkg.sv */
package openram_wb_pkg;

`include "openram_wb_settings.svh"

    // Bus and RAM data word
    typedef logic [`WB_DATA_WIDTH-1:0] wb_data_t;

    // Byte select, doubles as RAM write mask
    typedef logic [`WB_SEL_WIDTH-1:0] wb_sel_t;

    // One wait-state count
    typedef logic [`LAT_CNTR_WIDTH-1:0] lat_cnt_t;

    // Latency register, port 1 fields in the upper half
    typedef struct packed {
        lat_cnt_t p1_prefetch;  // Cycles before the RAM clock pulse
        lat_cnt_t p1_read;      // Cycles after the pulse before ack
        lat_cnt_t p0_prefetch;
        lat_cnt_t p0_read;
    } lat_cfg_t;

endpackage

/* openram_wb_settings.svh */
`ifndef OPENRAM_WB_SETTINGS_SVH
`define OPENRAM_WB_SETTINGS_SVH

// RAM geometry
// Word address bits of the macro, 8 gives 256 words of 32 bits
`define RAM_ADDR_WIDTH 8

// Bus data width in bits and bytes
`define WB_DATA_WIDTH 32
`define WB_SEL_WIDTH 4

// Wait-state pacing
// Width of a single prefetch or read wait count
`define LAT_CNTR_WIDTH 4

// All four counts start at 2
// Order is p1 prefetch, p1 read, p0 prefetch, p0 read
`define LAT_RESET_VALUE 16'h2222

`endif

/* openram_wb_subsys.sv */
`timescale 1ns/1ns

`include "openram_wb_settings.svh"

module openram_wb_subsys
    import openram_wb_pkg::*;
(
    input  logic                       wb_a_clk_i,
    input  logic                       wb_a_rst_i,
    input  logic                       writable_port_req_i,

    input  logic                       wbs_a_cyc_i,
    input  logic                       wbs_a_stb_i,
    input  logic                       wbs_a_we_i,
    input  wb_sel_t                    wbs_a_sel_i,
    input  wb_data_t                   wbs_a_dat_i,
    input  logic [`RAM_ADDR_WIDTH+2:0] wbs_a_adr_i,
    output logic                       wbs_a_ack_o,
    output wb_data_t                   wbs_a_dat_o,

    input  logic                       wbs_b_cyc_i,
    input  logic                       wbs_b_stb_i,
    input  logic                       wbs_b_we_i,
    input  wb_sel_t                    wbs_b_sel_i,
    input  wb_data_t                   wbs_b_dat_i,
    input  logic [`RAM_ADDR_WIDTH+1:0] wbs_b_adr_i,
    output logic                       wbs_b_ack_o,
    output wb_data_t                   wbs_b_dat_o
);

    // Wrapper to macro pins
    logic                       ram_clk0, ram_csb0, ram_web0;
    logic                       ram_clk1, ram_csb1;
    wb_sel_t                    ram_wmask0;
    logic [`RAM_ADDR_WIDTH-1:0] ram_addr0, ram_addr1;
    wb_data_t                   ram_din0, ram_dout0, ram_dout1;

    wb_openram_wrapper wrapper_i (
        .wb_a_clk_i          (wb_a_clk_i),
        .wb_a_rst_i          (wb_a_rst_i),
        .writable_port_req_i (writable_port_req_i),
        .wbs_a_cyc_i         (wbs_a_cyc_i),
        .wbs_a_stb_i         (wbs_a_stb_i),
        .wbs_a_we_i          (wbs_a_we_i),
        .wbs_a_sel_i         (wbs_a_sel_i),
        .wbs_a_dat_i         (wbs_a_dat_i),
        .wbs_a_adr_i         (wbs_a_adr_i),
        .wbs_a_ack_o         (wbs_a_ack_o),
        .wbs_a_dat_o         (wbs_a_dat_o),
        .wbs_b_cyc_i         (wbs_b_cyc_i),
        .wbs_b_stb_i         (wbs_b_stb_i),
        .wbs_b_we_i          (wbs_b_we_i),
        .wbs_b_sel_i         (wbs_b_sel_i),
        .wbs_b_dat_i         (wbs_b_dat_i),
        .wbs_b_adr_i         (wbs_b_adr_i),
        .wbs_b_ack_o         (wbs_b_ack_o),
        .wbs_b_dat_o         (wbs_b_dat_o),
        .ram_clk0_o          (ram_clk0),
        .ram_csb0_o          (ram_csb0),
        .ram_web0_o          (ram_web0),
        .ram_wmask0_o        (ram_wmask0),
        .ram_addr0_o         (ram_addr0),
        .ram_din0_o          (ram_din0),
        .ram_dout0_i         (ram_dout0),
        .ram_clk1_o          (ram_clk1),
        .ram_csb1_o          (ram_csb1),
        .ram_addr1_o         (ram_addr1),
        .ram_dout1_i         (ram_dout1)
    );

    openram_sram_model sram_i (
        .ram_clk0_i   (ram_clk0),
        .ram_csb0_i   (ram_csb0),
        .ram_web0_i   (ram_web0),
        .ram_wmask0_i (ram_wmask0),
        .ram_addr0_i  (ram_addr0),
        .ram_din0_i   (ram_din0),
        .ram_dout0_o  (ram_dout0),
        .ram_clk1_i   (ram_clk1),
        .ram_csb1_i   (ram_csb1),
        .ram_addr1_i  (ram_addr1),
        .ram_dout1_o  (ram_dout1)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the testbench, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f openram_wb.f --top-module tb_openram_wb \
    -o sim_openram_wb \
    && ./obj_dir/sim_openram_wb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0

/* tb_openram_wb_tasks.svh */
// Port A access, samples just after the drive and then at later falling edges
task automatic port_a_transfer(input  logic                       we,
                               input  logic [`RAM_ADDR_WIDTH+2:0] adr,
                               input  wb_data_t                   dat,
                               input  wb_sel_t                    sel,
                               output wb_data_t                   rdat,
                               output int                         lat);
    int   n;
    logic early;            // Ack already up before the first rising edge
    wbs_a_cyc_i = 1'b1;
    wbs_a_stb_i = 1'b1;
    wbs_a_we_i  = we;
    wbs_a_sel_i = sel;
    wbs_a_adr_i = adr;
    wbs_a_dat_i = dat;
    n = 0;
    #1;
    early = wbs_a_ack_o;    // Only a combinational ack is high this soon
    do begin
        @(negedge wb_a_clk_i);
        n++;
        if (we) begin
            check_value("wbs_a_dat_o echo", dat, wbs_a_dat_o);  // Write data comes straight back
        end
    end while (!wbs_a_ack_o && n < ACK_TIMEOUT);
    assert (wbs_a_ack_o) else begin
        $display("Port A got no acknowledge within %0d cycles at %0t ns", ACK_TIMEOUT, $time);
        timeouts++;
    end
    rdat = wbs_a_dat_o;
    // Edges after the one that first sees the strobe, -1 when ack comes with the strobe
    lat  = early ? -1 : n - 1;
    wbs_a_cyc_i = 1'b0;
    wbs_a_stb_i = 1'b0;
    wbs_a_we_i  = 1'b0;
    @(negedge wb_a_clk_i);  // Strobe low for one full cycle
endtask

// Port B access, same handshake without config space
task automatic port_b_transfer(input  logic                       we,
                               input  logic [`RAM_ADDR_WIDTH+1:0] adr,
                               input  wb_data_t                   dat,
                               input  wb_sel_t                    sel,
                               output wb_data_t                   rdat,
                               output int                         lat);
    int n;
    wbs_b_cyc_i = 1'b1;
    wbs_b_stb_i = 1'b1;
    wbs_b_we_i  = we;
    wbs_b_sel_i = sel;
    wbs_b_adr_i = adr;
    wbs_b_dat_i = dat;
    n = 0;
    do begin
        @(negedge wb_a_clk_i);
        n++;
        if (we) begin
            check_value("wbs_b_dat_o echo", dat, wbs_b_dat_o);
        end
    end while (!wbs_b_ack_o && n < ACK_TIMEOUT);
    assert (wbs_b_ack_o) else begin
        $display("Port B got no acknowledge within %0d cycles at %0t ns", ACK_TIMEOUT, $time);
        timeouts++;
    end
    rdat = wbs_b_dat_o;
    lat  = n - 1;
    wbs_b_cyc_i = 1'b0;
    wbs_b_stb_i = 1'b0;
    wbs_b_we_i  = 1'b0;
    @(negedge wb_a_clk_i);
endtask

/* tb_openram_wb.sv */
`timescale 1ns/1ns

`include "openram_wb_settings.svh"

module tb_openram_wb
    import openram_wb_pkg::*;
();

    localparam int ACK_TIMEOUT = 64;                  // Worst case latency is 32
    localparam int WORDS       = 1 << `RAM_ADDR_WIDTH;

    logic                       wb_a_clk_i = 1'b0;
    logic                       wb_a_rst_i;
    logic                       writable_port_req_i;
    logic                       wbs_a_cyc_i, wbs_a_stb_i, wbs_a_we_i;
    wb_sel_t                    wbs_a_sel_i;
    wb_data_t                   wbs_a_dat_i;
    logic [`RAM_ADDR_WIDTH+2:0] wbs_a_adr_i;
    logic                       wbs_a_ack_o;
    wb_data_t                   wbs_a_dat_o;
    logic                       wbs_b_cyc_i, wbs_b_stb_i, wbs_b_we_i;
    wb_sel_t                    wbs_b_sel_i;
    wb_data_t                   wbs_b_dat_i;
    logic [`RAM_ADDR_WIDTH+1:0] wbs_b_adr_i;
    logic                       wbs_b_ack_o;
    wb_data_t                   wbs_b_dat_o;

    int          checks       = 0;
    int          value_errors = 0;
    int          timeouts     = 0;
    logic [15:0] lfsr         = 16'd97;
    wb_data_t    cfg_exp      = 32'h0202_0202;   // All four counts at 2 after reset
    logic        swap_exp     = 1'b0;            // Port B owns the writable port when set
    wb_data_t    sb_mem [0:WORDS-1];             // Mirror of the RAM contents

    always #4 wb_a_clk_i = ~wb_a_clk_i;          // 8 ns period

    openram_wb_subsys openram_wb_subsys_i (.*);

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};  // One step per bit
        end
    endtask

    function automatic wb_data_t masked_merge(input wb_data_t old_w, input wb_data_t new_w,
                                              input wb_sel_t mask);
        wb_data_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Prefetch plus read plus the pulse and capture cycles
    function automatic int expected_latency(input logic owns_rw);
        if (owns_rw) begin
            return 32'(cfg_exp[11:8]) + 32'(cfg_exp[3:0]) + 2;
        end
        return 32'(cfg_exp[27:24]) + 32'(cfg_exp[19:16]) + 2;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, exp, got);
            value_errors++;
        end
    endtask

    `include "tb_openram_wb_tasks.svh"

    task automatic csr_write(input wb_data_t dat);
        wb_data_t rdat;
        int       lat;
        port_a_transfer(1'b1, '0, dat, 4'hF, rdat, lat);
        check_value("csr wbs_a_ack_o latency", -1, lat);    // Ack together with the strobe
        cfg_exp = dat & 32'h0F0F_0F0F;
    endtask

    task automatic csr_read_check(input wb_data_t exp);
        wb_data_t rdat;
        int       lat;
        port_a_transfer(1'b0, '0, '0, 4'hF, rdat, lat);
        check_value("csr wbs_a_ack_o latency", -1, lat);
        check_value("csr wbs_a_dat_o", exp, rdat);
    endtask

    // One RAM access with latency check and scoreboard update or compare
    task automatic ram_access(input logic on_b, input logic we,
                              input logic [`RAM_ADDR_WIDTH-1:0] wa,
                              input wb_data_t dat, input wb_sel_t sel);
        wb_data_t rdat;
        int       lat;
        logic     owns_rw;
        string    tag;
        owns_rw = (on_b == swap_exp);
        tag     = on_b ? "wbs_b" : "wbs_a";
        if (on_b) begin
            port_b_transfer(we, {wa, 2'b00}, dat, sel, rdat, lat);
        end else begin
            port_a_transfer(we, {1'b1, wa, 2'b00}, dat, sel, rdat, lat);
        end
        check_value({tag, "_ack_o latency"}, expected_latency(owns_rw), lat);
        if (we && owns_rw) begin
            sb_mem[wa] = masked_merge(sb_mem[wa], dat, sel);   // Read-only side drops writes
        end
        if (!we) begin
            check_value({tag, "_dat_o"}, sb_mem[wa], rdat);
        end
    endtask

    initial begin
        logic [31:0] bits;
        logic [31:0] word;
        logic [31:0] mask;
        for (int i = 0; i < WORDS; i++) begin
            sb_mem[i] = '0;
        end
        wb_a_rst_i          = 1'b1;
        writable_port_req_i = 1'b0;
        wbs_a_cyc_i = 1'b0;
        wbs_a_stb_i = 1'b0;
        wbs_a_we_i  = 1'b0;
        wbs_a_sel_i = '0;
        wbs_a_dat_i = '0;
        wbs_a_adr_i = '0;
        wbs_b_cyc_i = 1'b0;
        wbs_b_stb_i = 1'b0;
        wbs_b_we_i  = 1'b0;
        wbs_b_sel_i = '0;
        wbs_b_dat_i = '0;
        wbs_b_adr_i = '0;
        repeat (3) @(negedge wb_a_clk_i);
        wb_a_rst_i = 1'b0;

        // Reset state and default latencies
        check_value("wbs_a_ack_o", 32'd0, {31'd0, wbs_a_ack_o});
        check_value("wbs_b_ack_o", 32'd0, {31'd0, wbs_b_ack_o});
        csr_read_check(32'h0202_0202);

        // Config write keeps only the low nibbles
        take_bits(32, word);
        csr_write(word);
        csr_read_check(word & 32'h0F0F_0F0F);

        // Masked writes on A, reads on both ports
        for (int i = 0; i < 12; i++) begin
            take_bits(`RAM_ADDR_WIDTH, bits);
            take_bits(32, word);
            take_bits(4, mask);
            ram_access(1'b0, 1'b1, bits[`RAM_ADDR_WIDTH-1:0], word, mask[3:0]);
            ram_access(1'b0, 1'b0, bits[`RAM_ADDR_WIDTH-1:0], '0, 4'hF);
            ram_access(1'b1, 1'b0, bits[`RAM_ADDR_WIDTH-1:0], '0, 4'hF);
        end

        // Latency sweep, all-zero counts first
        for (int k = 0; k < 5; k++) begin
            word = '0;
            if (k != 0) begin
                take_bits(32, word);
            end
            csr_write(word);
            csr_read_check(cfg_exp);
            take_bits(`RAM_ADDR_WIDTH, bits);
            ram_access(1'b0, 1'b0, bits[`RAM_ADDR_WIDTH-1:0], '0, 4'hF);
            ram_access(1'b1, 1'b0, bits[`RAM_ADDR_WIDTH-1:0], '0, 4'hF);
        end

        // B is read-only before the swap
        take_bits(`RAM_ADDR_WIDTH, bits);
        take_bits(32, word);
        ram_access(1'b1, 1'b1, bits[`RAM_ADDR_WIDTH-1:0], word, 4'hF);
        ram_access(1'b0, 1'b0, bits[`RAM_ADDR_WIDTH-1:0], '0, 4'hF);

        // Hand the writable port to B, both ports idle
        writable_port_req_i = 1'b1;
        repeat (2) @(negedge wb_a_clk_i);
        swap_exp = 1'b1;
        for (int i = 0; i < 8; i++) begin
            take_bits(`RAM_ADDR_WIDTH, bits);
            take_bits(32, word);
            take_bits(4, mask);
            ram_access(1'b1, 1'b1, bits[`RAM_ADDR_WIDTH-1:0], word, mask[3:0]);
            ram_access(1'b1, 1'b0, bits[`RAM_ADDR_WIDTH-1:0], '0, 4'hF);
            ram_access(1'b0, 1'b0, bits[`RAM_ADDR_WIDTH-1:0], '0, 4'hF);
            take_bits(32, word);
            ram_access(1'b0, 1'b1, bits[`RAM_ADDR_WIDTH-1:0], word, 4'hF);  // Dropped
            ram_access(1'b1, 1'b0, bits[`RAM_ADDR_WIDTH-1:0], '0, 4'hF);
        end

        // Config space on A unaffected by ownership
        csr_read_check(cfg_exp);
        take_bits(32, word);
        csr_write(word);
        csr_read_check(cfg_exp);

        $display("Checks %0d, value errors %0d, timeouts %0d", checks, value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* wb_csr_bank.sv */
`timescale 1ns/1ns

`include "openram_wb_settings.svh"

module wb_csr_bank
    import openram_wb_pkg::*;
(
    input  logic     wb_a_clk_i,
    input  logic     wb_a_rst_i,
    input  logic     writable_port_req_i,  // Raw ownership request

    input  logic     wbs_a_cyc_i,
    input  logic     wbs_a_stb_i,
    input  logic     wbs_a_we_i,
    input  logic     wbs_a_csr_sel_i,      // High when port A targets the register
    input  wb_data_t wbs_a_dat_i,

    output logic     csr_ack_o,
    output wb_data_t csr_dat_o,
    output lat_cfg_t lat_cfg_o,
    output logic     port_swap_o           // High gives port B the writable RAM port
);

    // Each count sits in the low part of its own byte
    localparam int PAD = 8 - `LAT_CNTR_WIDTH;

    logic     csr_req;      // Live config access on port A
    lat_cfg_t lat_cfg_r;
    logic     port_swap_r;

    assign csr_req = wbs_a_cyc_i & wbs_a_stb_i & wbs_a_csr_sel_i;

    // Ownership sampled half a cycle away from the controllers
    always_ff @(negedge wb_a_clk_i) begin
        if (wb_a_rst_i) begin
            port_swap_r <= 1'b0;
        end else begin
            port_swap_r <= writable_port_req_i;
        end
    end

    // Latency register, one nibble taken from each byte
    always_ff @(posedge wb_a_clk_i) begin
        if (wb_a_rst_i) begin
            lat_cfg_r <= `LAT_RESET_VALUE;
        end else if (csr_req && wbs_a_we_i) begin
            lat_cfg_r.p1_prefetch <= wbs_a_dat_i[24 +: `LAT_CNTR_WIDTH];
            lat_cfg_r.p1_read     <= wbs_a_dat_i[16 +: `LAT_CNTR_WIDTH];
            lat_cfg_r.p0_prefetch <= wbs_a_dat_i[8 +: `LAT_CNTR_WIDTH];
            lat_cfg_r.p0_read     <= wbs_a_dat_i[0 +: `LAT_CNTR_WIDTH];
        end
    end

    // Zero-padded readback
    assign csr_dat_o = {{PAD{1'b0}}, lat_cfg_r.p1_prefetch,
                        {PAD{1'b0}}, lat_cfg_r.p1_read,
                        {PAD{1'b0}}, lat_cfg_r.p0_prefetch,
                        {PAD{1'b0}}, lat_cfg_r.p0_read};

    assign csr_ack_o   = csr_req;       // No wait states on the register
    assign lat_cfg_o   = lat_cfg_r;
    assign port_swap_o = port_swap_r;

endmodule

/* wb_openram_wrapper.sv */
`timescale 1ns/1ns

`include "openram_wb_settings.svh"

module wb_openram_wrapper
    import openram_wb_pkg::*;
(
    input  logic                       wb_a_clk_i,
    input  logic                       wb_a_rst_i,
    input  logic                       writable_port_req_i,

    // Port A, top address bit picks config or RAM
    input  logic                       wbs_a_cyc_i,
    input  logic                       wbs_a_stb_i,
    input  logic                       wbs_a_we_i,
    input  wb_sel_t                    wbs_a_sel_i,
    input  wb_data_t                   wbs_a_dat_i,
    input  logic [`RAM_ADDR_WIDTH+2:0] wbs_a_adr_i,
    output logic                       wbs_a_ack_o,
    output wb_data_t                   wbs_a_dat_o,

    // Port B, RAM only
    input  logic                       wbs_b_cyc_i,
    input  logic                       wbs_b_stb_i,
    input  logic                       wbs_b_we_i,
    input  wb_sel_t                    wbs_b_sel_i,
    input  wb_data_t                   wbs_b_dat_i,
    input  logic [`RAM_ADDR_WIDTH+1:0] wbs_b_adr_i,
    output logic                       wbs_b_ack_o,
    output wb_data_t                   wbs_b_dat_o,

    // RAM port 0, read-write
    output logic                       ram_clk0_o,
    output logic                       ram_csb0_o,
    output logic                       ram_web0_o,
    output wb_sel_t                    ram_wmask0_o,
    output logic [`RAM_ADDR_WIDTH-1:0] ram_addr0_o,
    output wb_data_t                   ram_din0_o,
    input  wb_data_t                   ram_dout0_i,

    // RAM port 1, read only
    output logic                       ram_clk1_o,
    output logic                       ram_csb1_o,
    output logic [`RAM_ADDR_WIDTH-1:0] ram_addr1_o,
    input  wb_data_t                   ram_dout1_i
);

    logic     swap;             // Port B owns RAM port 0 when set
    lat_cfg_t lat_cfg;
    logic     a_csr_sel;
    logic     a_ram_cyc;
    logic     a_ram_stb;
    logic     csr_ack;
    wb_data_t csr_dat;
    logic     p0_cyc, p0_stb, p0_we, p0_ack;
    logic     p1_cyc, p1_stb, p1_we, p1_ack;
    wb_data_t p0_dat, p1_dat;
    wb_data_t a_dout, b_dout;

    assign a_csr_sel = !wbs_a_adr_i[`RAM_ADDR_WIDTH+2];  // Low half is config space
    assign a_ram_cyc = wbs_a_cyc_i & !a_csr_sel;
    assign a_ram_stb = wbs_a_stb_i & !a_csr_sel;         // Keep config hits off the RAM

    wb_csr_bank csr_i (
        .wb_a_clk_i          (wb_a_clk_i),
        .wb_a_rst_i          (wb_a_rst_i),
        .writable_port_req_i (writable_port_req_i),
        .wbs_a_cyc_i         (wbs_a_cyc_i),
        .wbs_a_stb_i         (wbs_a_stb_i),
        .wbs_a_we_i          (wbs_a_we_i),
        .wbs_a_csr_sel_i     (a_csr_sel),
        .wbs_a_dat_i         (wbs_a_dat_i),
        .csr_ack_o           (csr_ack),
        .csr_dat_o           (csr_dat),
        .lat_cfg_o           (lat_cfg),
        .port_swap_o         (swap)
    );

    // Owner steering toward the RAM
    assign p0_cyc       = swap ? wbs_b_cyc_i : a_ram_cyc;
    assign p0_stb       = swap ? wbs_b_stb_i : a_ram_stb;
    assign p0_we        = swap ? wbs_b_we_i  : wbs_a_we_i;
    assign ram_wmask0_o = swap ? wbs_b_sel_i : wbs_a_sel_i;
    assign ram_din0_o   = swap ? wbs_b_dat_i : wbs_a_dat_i;
    assign ram_addr0_o  = swap ? wbs_b_adr_i[`RAM_ADDR_WIDTH+1:2]
                               : wbs_a_adr_i[`RAM_ADDR_WIDTH+1:2];

    assign p1_cyc       = swap ? a_ram_cyc  : wbs_b_cyc_i;
    assign p1_stb       = swap ? a_ram_stb  : wbs_b_stb_i;
    assign p1_we        = swap ? wbs_a_we_i : wbs_b_we_i;
    assign ram_addr1_o  = swap ? wbs_a_adr_i[`RAM_ADDR_WIDTH+1:2]
                               : wbs_b_adr_i[`RAM_ADDR_WIDTH+1:2];

    wb_port_control #(.READ_ONLY(1'b0)) port0_rw (
        .wb_a_clk_i        (wb_a_clk_i),
        .wb_a_rst_i        (wb_a_rst_i),
        .wbs_cyc_i         (p0_cyc),
        .wbs_stb_i         (p0_stb),
        .wbs_we_i          (p0_we),
        .prefetch_cycles_i (lat_cfg.p0_prefetch),
        .read_cycles_i     (lat_cfg.p0_read),
        .ram_dout_i        (ram_dout0_i),
        .wbs_ack_o         (p0_ack),
        .wbs_dat_o         (p0_dat),
        .ram_clk_o         (ram_clk0_o),
        .ram_csb_o         (ram_csb0_o),
        .ram_web_o         (ram_web0_o)
    );

    wb_port_control #(.READ_ONLY(1'b1)) port1_r (
        .wb_a_clk_i        (wb_a_clk_i),
        .wb_a_rst_i        (wb_a_rst_i),
        .wbs_cyc_i         (p1_cyc),
        .wbs_stb_i         (p1_stb),
        .wbs_we_i          (p1_we),
        .prefetch_cycles_i (lat_cfg.p1_prefetch),
        .read_cycles_i     (lat_cfg.p1_read),
        .ram_dout_i        (ram_dout1_i),
        .wbs_ack_o         (p1_ack),
        .wbs_dat_o         (p1_dat),
        .ram_clk_o         (ram_clk1_o),
        .ram_csb_o         (ram_csb1_o),
        .ram_web_o         ()           // Port 1 has no write pin
    );

    // Responses back to the bus, writes echo their own data
    assign wbs_a_ack_o = a_csr_sel ? csr_ack : (swap ? p1_ack : p0_ack);
    assign a_dout      = a_csr_sel ? csr_dat : (swap ? p1_dat : p0_dat);
    assign wbs_a_dat_o = wbs_a_we_i ? wbs_a_dat_i : a_dout;

    assign wbs_b_ack_o = swap ? p0_ack : p1_ack;
    assign b_dout      = swap ? p0_dat : p1_dat;
    assign wbs_b_dat_o = wbs_b_we_i ? wbs_b_dat_i : b_dout;

endmodule

/* wb_port_control.sv */
`timescale 1ns/1ns

module wb_port_control
    import openram_wb_pkg::*;
#(
    parameter bit READ_ONLY = 1'b0      // Set on the read-only RAM port
)
(
    input  logic     wb_a_clk_i,
    input  logic     wb_a_rst_i,

    input  logic     wbs_cyc_i,
    input  logic     wbs_stb_i,
    input  logic     wbs_we_i,
    input  lat_cnt_t prefetch_cycles_i,  // Extra cycles with csb low before the pulse
    input  lat_cnt_t read_cycles_i,      // Cycles between pulse and ack
    input  wb_data_t ram_dout_i,

    output logic     wbs_ack_o,
    output wb_data_t wbs_dat_o,
    output logic     ram_clk_o,          // One-cycle registered pulse
    output logic     ram_csb_o,          // Active low
    output logic     ram_web_o           // Active low
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREFETCH,    // Address setup plus prefetch waits
        ST_PULSE,       // ram_clk high
        ST_READ,        // Read waits
        ST_ACK,         // ack_o high
        ST_DONE         // Wait for strobe to fall
    } state_t;

    state_t   state;
    lat_cnt_t cnt;          // Shared down-counter for both wait phases
    logic     req;
    logic     ack_set;      // Last cycle of the read wait

    assign req = wbs_cyc_i & wbs_stb_i;

    // Zero read count finishes straight out of the pulse
    assign ack_set = ((state == ST_PULSE) && (read_cycles_i == '0)) ||
                     ((state == ST_READ) && (cnt == '0));

    always_ff @(posedge wb_a_clk_i) begin
        if (wb_a_rst_i) begin
            state     <= ST_IDLE;
            cnt       <= '0;
            wbs_ack_o <= 1'b0;
            ram_clk_o <= 1'b0;
            ram_csb_o <= 1'b1;
            ram_web_o <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: if (req) begin
                    state     <= ST_PREFETCH;
                    cnt       <= prefetch_cycles_i;
                    ram_csb_o <= 1'b0;
                    ram_web_o <= !(wbs_we_i && !READ_ONLY);  // Read-only port never writes
                end
                ST_PREFETCH: if (cnt == '0) begin
                    state     <= ST_PULSE;
                    ram_clk_o <= 1'b1;      // Macro samples on this edge
                end else begin
                    cnt <= cnt - 1'b1;
                end
                ST_PULSE: begin
                    ram_clk_o <= 1'b0;
                    state     <= ack_set ? ST_ACK : ST_READ;
                    cnt       <= read_cycles_i - 1'b1;  // Pulse cycle counts as one
                end
                ST_READ: if (ack_set) begin
                    state <= ST_ACK;
                end else begin
                    cnt <= cnt - 1'b1;
                end
                ST_ACK: begin
                    ram_csb_o <= 1'b1;
                    ram_web_o <= 1'b1;
                    state     <= req ? ST_DONE : ST_IDLE;
                end
                ST_DONE: if (!req) begin
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
            wbs_ack_o <= ack_set;   // Single-cycle ack
        end
    end

    // Read data held from capture until the next access
    always_ff @(posedge wb_a_clk_i) begin
        if (ack_set) begin
            wbs_dat_o <= ram_dout_i;
        end
    end

endmodule
